//--- design/addr_xlate.sv
`timescale 1ns/1ps

module addr_xlate import mips_mem_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       req_valid,
  output logic       req_ready,
  input  fetch_req_t req,
  output logic       xl_valid,
  input  logic       xl_ready,
  output xlate_t     xl
);

  logic [2:0] seg;
  logic       misaligned;
  logic       unmapped;
  xlate_t     xl_next;

  assign seg        = req.vaddr[31:29];
  assign misaligned = |req.vaddr[1:0];
  assign unmapped   = (seg == seg_kseg0) || (seg == seg_kseg1);

  // kseg0 and kseg1 both map onto the low 512 MB
  always_comb begin
    xl_next.paddr  = {3'b000, req.vaddr[28:0]};
    xl_next.err    = misaligned || !unmapped;
    xl_next.cached = !xl_next.err && (seg == seg_kseg0);
  end

  // accept when empty or when the held result leaves this cycle
  assign req_ready = !xl_valid || xl_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      xl_valid <= 1'b0;
    end else if (req_ready) begin
      xl_valid <= req_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid && req_ready) begin
      xl <= xl_next;
    end
  end

  // held result must not move while the cache is busy
  a_xl_stable: assert property (@(posedge clk) disable iff (!rst_n)
    xl_valid && !xl_ready |=> xl_valid && $stable(xl));

endmodule

//--- design/axi_pkg.sv
package axi_pkg;

  // arburst encoding
  localparam logic [1:0] burst_incr = 2'b01;

  // arsize encoding for 4 bytes per beat
  localparam logic [2:0] size_word = 3'b010;

  // read address channel payload
  typedef struct packed {
    logic [3:0]  id;
    logic [31:0] addr;
    logic [7:0]  len;
    logic [2:0]  size;
    logic [1:0]  burst;
  } axi_ar_t;

  // read data channel payload
  typedef struct packed {
    logic [3:0]  id;
    logic [31:0] data;
    logic [1:0]  resp;
    logic        last;
  } axi_r_t;

endpackage

//--- design/axi_read_bridge.sv
`timescale 1ns/1ps

module axi_read_bridge import mips_mem_pkg::*, axi_pkg::*; #(
  parameter int axi_id = 0
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        mem_valid,
  output logic        mem_ready,
  input  mem_req_t    mem,
  output logic        beat_valid,
  output logic [31:0] beat_data,
  output logic        beat_last,
  output logic        ar_valid,
  input  logic        ar_ready,
  output axi_ar_t     ar,
  input  logic        r_valid,
  output logic        r_ready,
  input  axi_r_t      r
);

  logic [31:0] addr_q;
  logic [7:0]  len_q;

  // one burst at a time, from request until the last beat
  assign mem_ready = !ar_valid && !r_ready;

  assign ar = '{
    id:    4'(axi_id),
    addr:  addr_q,
    len:   len_q,
    size:  size_word,
    burst: burst_incr
  };

  // R beats go straight through, rresp and rid ignored
  assign beat_valid = r_valid && r_ready;
  assign beat_data  = r.data;
  assign beat_last  = r.last;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ar_valid <= 1'b0;
      r_ready  <= 1'b0;
    end else begin
      if (mem_valid && mem_ready) begin
        ar_valid <= 1'b1;
      end else if (ar_valid && ar_ready) begin
        ar_valid <= 1'b0;
      end
      if (ar_valid && ar_ready) begin
        r_ready <= 1'b1;
      end else if (r_valid && r_ready && r.last) begin
        r_ready <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mem_valid && mem_ready) begin
      addr_q <= mem.addr;
      len_q  <= mem.len;
    end
  end

  a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
    ar_valid && !ar_ready |=> ar_valid && $stable(ar));

endmodule

//--- design/fetch_cache.sv
`timescale 1ns/1ps

module fetch_cache import mips_mem_pkg::*; #(
  parameter int line_words = 4,
  parameter int sets       = 16
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        xl_valid,
  output logic        xl_ready,
  input  xlate_t      xl,
  output logic        resp_valid,
  input  logic        resp_ready,
  output fetch_resp_t resp,
  output logic        mem_valid,
  input  logic        mem_ready,
  output mem_req_t    mem,
  input  logic        beat_valid,
  input  logic [31:0] beat_data,
  input  logic        beat_last
);

  localparam int off_w = $clog2(line_words);
  localparam int idx_w = $clog2(sets);
  localparam int tag_w = 30 - off_w - idx_w;

  typedef enum logic [2:0] {
    st_idle,
    st_lookup,
    st_request,
    st_refill,
    st_respond
  } state_t;

  state_t           state;
  xlate_t           req_q;
  logic [7:0]       beat_cnt;
  logic [31:0]      unc_q;
  logic [sets-1:0]  valid_q;
  logic [tag_w-1:0] tag_mem [sets];
  logic [31:0]      data_mem [sets][line_words];

  logic [off_w-1:0] off;
  logic [idx_w-1:0] idx;
  logic [tag_w-1:0] tag;
  logic             hit;
  logic             lookup_done;

  // word offset, set index and tag of the held request
  assign off = req_q.paddr[off_w+1:2];
  assign idx = req_q.paddr[off_w+2 +: idx_w];
  assign tag = req_q.paddr[31 -: tag_w];

  assign hit         = req_q.cached && valid_q[idx] && (tag_mem[idx] == tag);
  assign lookup_done = req_q.err || hit;

  assign xl_ready   = (state == st_idle);
  assign mem_valid  = (state == st_request);
  assign resp_valid = (state == st_respond) || ((state == st_lookup) && lookup_done);

  // line-aligned burst for cached misses, single beat otherwise
  always_comb begin
    if (req_q.cached) begin
      mem.addr = {req_q.paddr[31:off_w+2], {(off_w + 2){1'b0}}};
      mem.len  = 8'(line_words - 1);
    end else begin
      mem.addr = req_q.paddr;
      mem.len  = 8'd0;
    end
  end

  // arrays only change in refill, so resp holds while stalled
  always_comb begin
    resp.err = req_q.err;
    if (req_q.err) begin
      resp.rdata = '0;
    end else if (req_q.cached) begin
      resp.rdata = data_mem[idx][off];
    end else begin
      resp.rdata = unc_q;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= st_idle;
      beat_cnt <= '0;
      valid_q  <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (xl_valid) begin
            state <= st_lookup;
          end
        end
        st_lookup: begin
          if (!lookup_done) begin
            state <= st_request;
          end else if (resp_ready) begin
            state <= st_idle;
          end else begin
            state <= st_respond;
          end
        end
        st_request: begin
          if (mem_ready) begin
            state    <= st_refill;
            beat_cnt <= '0;
          end
        end
        st_refill: begin
          if (beat_valid) begin
            beat_cnt <= beat_cnt + 8'd1;
            if (beat_last) begin
              state <= st_respond;
              // uncached data never marks a line
              if (req_q.cached) begin
                valid_q[idx] <= 1'b1;
              end
            end
          end
        end
        st_respond: begin
          if (resp_ready) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (xl_valid && xl_ready) begin
      req_q <= xl;
    end
    if ((state == st_refill) && beat_valid) begin
      if (req_q.cached) begin
        data_mem[idx][beat_cnt[off_w-1:0]] <= beat_data;
      end else begin
        unc_q <= beat_data;
      end
      if (beat_last && req_q.cached) begin
        tag_mem[idx] <= tag;
      end
    end
  end

  a_resp_stable: assert property (@(posedge clk) disable iff (!rst_n)
    resp_valid && !resp_ready |=> resp_valid && $stable(resp));

  // bridge must end the burst on the beat count we asked for
  a_beat_count: assert property (@(posedge clk) disable iff (!rst_n)
    (state == st_refill) && beat_valid |-> beat_last == (beat_cnt == mem.len));

endmodule

//--- design/fetch_mem_top.sv
`timescale 1ns/1ps

module fetch_mem_top import mips_mem_pkg::*, axi_pkg::*; #(
  parameter int line_words = 4,
  parameter int sets       = 16,
  parameter int axi_id     = 0
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        req_valid,
  output logic        req_ready,
  input  fetch_req_t  req,
  output logic        resp_valid,
  input  logic        resp_ready,
  output fetch_resp_t resp,
  output logic        ar_valid,
  input  logic        ar_ready,
  output axi_ar_t     ar,
  input  logic        r_valid,
  output logic        r_ready,
  input  axi_r_t      r
);

  // translation to cache
  logic   xl_valid;
  logic   xl_ready;
  xlate_t xl;

  // cache to bridge
  logic     mem_valid;
  logic     mem_ready;
  mem_req_t mem;

  // bridge beats back to the cache
  logic        beat_valid;
  logic [31:0] beat_data;
  logic        beat_last;

  addr_xlate u_addr_xlate (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .xl_valid  (xl_valid),
    .xl_ready  (xl_ready),
    .xl        (xl)
  );

  fetch_cache #(
    .line_words (line_words),
    .sets       (sets)
  ) u_fetch_cache (
    .clk        (clk),
    .rst_n      (rst_n),
    .xl_valid   (xl_valid),
    .xl_ready   (xl_ready),
    .xl         (xl),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .resp       (resp),
    .mem_valid  (mem_valid),
    .mem_ready  (mem_ready),
    .mem        (mem),
    .beat_valid (beat_valid),
    .beat_data  (beat_data),
    .beat_last  (beat_last)
  );

  axi_read_bridge #(
    .axi_id (axi_id)
  ) u_axi_read_bridge (
    .clk        (clk),
    .rst_n      (rst_n),
    .mem_valid  (mem_valid),
    .mem_ready  (mem_ready),
    .mem        (mem),
    .beat_valid (beat_valid),
    .beat_data  (beat_data),
    .beat_last  (beat_last),
    .ar_valid   (ar_valid),
    .ar_ready   (ar_ready),
    .ar         (ar),
    .r_valid    (r_valid),
    .r_ready    (r_ready),
    .r          (r)
  );

endmodule

//--- design/mips_mem_pkg.sv
package mips_mem_pkg;

  // top three virtual address bits of the unmapped segments
  localparam logic [2:0] seg_kseg0 = 3'b100;
  localparam logic [2:0] seg_kseg1 = 3'b101;

  // fetch request from the outside world
  typedef struct packed {
    logic [31:0] vaddr;
  } fetch_req_t;

  // translated request, addr_xlate to fetch_cache
  typedef struct packed {
    logic [31:0] paddr;
    logic        cached;
    logic        err;
  } xlate_t;

  // fetch response, rdata is zero on an address error
  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } fetch_resp_t;

  // memory read request, fetch_cache to axi_read_bridge
  typedef struct packed {
    logic [31:0] addr;
    logic [7:0]  len;
  } mem_req_t;

endpackage

//--- dv/axi_mem_model.sv
`timescale 1ns/1ps

module axi_mem_model import axi_pkg::*; #(
  parameter logic [31:0] mem_pattern = 32'h0,
  parameter logic [31:0] seed        = 32'hf972
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        ar_valid,
  output logic        ar_ready,
  input  axi_ar_t     ar,
  output logic        r_valid,
  input  logic        r_ready,
  output axi_r_t      r,
  output int          ar_count,
  output logic [3:0]  last_id,
  output logic [7:0]  last_len,
  output logic [31:0] last_addr,
  output logic [2:0]  last_size,
  output logic [1:0]  last_burst
);

  logic [31:0] rng_state;
  logic        ar_hs;
  logic        r_hs;
  logic        in_burst;
  logic [7:0]  beat;
  logic [1:0]  delay;

  // stall of 0 to 3 cycles from the upper LCG bits
  function automatic logic [1:0] next_delay();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state[17:16];
  endfunction

  initial begin
    rng_state = seed;
    ar_ready  = 1'b0;
    r_valid   = 1'b0;
    r         = '0;
  end

  // handshakes seen on the rising edge, answered on the falling edge
  always @(posedge clk) begin
    if (!rst_n) begin
      ar_hs      <= 1'b0;
      r_hs       <= 1'b0;
      ar_count   <= 0;
      last_id    <= '0;
      last_len   <= '0;
      last_addr  <= '0;
      last_size  <= '0;
      last_burst <= '0;
    end else begin
      ar_hs <= ar_valid && ar_ready;
      r_hs  <= r_valid && r_ready;
      if (ar_valid && ar_ready) begin
        ar_count   <= ar_count + 1;
        last_id    <= ar.id;
        last_len   <= ar.len;
        last_addr  <= ar.addr;
        last_size  <= ar.size;
        last_burst <= ar.burst;
      end
    end
  end

  always @(negedge clk) begin
    if (!rst_n) begin
      ar_ready = 1'b0;
      r_valid  = 1'b0;
      in_burst = 1'b0;
      beat     = '0;
      delay    = '0;
    end else if (!in_burst) begin
      if (ar_hs) begin
        ar_ready = 1'b0;
        in_burst = 1'b1;
        beat     = '0;
        delay    = next_delay();
      end else if (ar_valid && !ar_ready) begin
        if (delay == 2'd0) begin
          ar_ready = 1'b1;
        end else begin
          delay = delay - 2'd1;
        end
      end
    end else begin
      if (r_hs) begin
        r_valid = 1'b0;
        if (beat == last_len) begin
          in_burst = 1'b0;
        end else begin
          beat = beat + 8'd1;
        end
        delay = next_delay();
      end
      if (in_burst && !r_valid) begin
        if (delay == 2'd0) begin
          // word data is its own byte address mixed with the pattern
          r_valid = 1'b1;
          r.id    = last_id;
          r.data  = (last_addr + {22'b0, beat, 2'b00}) ^ mem_pattern;
          r.resp  = 2'b00;
          r.last  = (beat == last_len);
        end else begin
          delay = delay - 2'd1;
        end
      end
    end
  end

endmodule

//--- dv/tb_fetch_mem.sv
`timescale 1ns/1ps

module tb_fetch_mem import mips_mem_pkg::*, axi_pkg::*; ();

  localparam int          line_words     = 4;
  localparam int          sets           = 16;
  localparam int          axi_id         = 5;
  localparam int          line_bytes     = line_words * 4;
  localparam logic [31:0] mem_pattern    = 32'h5a3c_96e1;
  localparam int          timeout_cycles = 200;

  logic        clk;
  logic        rst_n;
  logic        req_valid;
  logic        req_ready;
  fetch_req_t  req;
  logic        resp_valid;
  logic        resp_ready;
  fetch_resp_t resp;
  logic        ar_valid;
  logic        ar_ready;
  axi_ar_t     ar;
  logic        r_valid;
  logic        r_ready;
  axi_r_t      r;
  int          ar_count;
  logic [3:0]  last_id;
  logic [7:0]  last_len;
  logic [31:0] last_addr;
  logic [2:0]  last_size;
  logic [1:0]  last_burst;
  logic [31:0] rng_state;

  fetch_mem_top #(
    .line_words (line_words),
    .sets       (sets),
    .axi_id     (axi_id)
  ) u_fetch_mem_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req        (req),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .resp       (resp),
    .ar_valid   (ar_valid),
    .ar_ready   (ar_ready),
    .ar         (ar),
    .r_valid    (r_valid),
    .r_ready    (r_ready),
    .r          (r)
  );

  axi_mem_model #(
    .mem_pattern (mem_pattern),
    .seed        (32'hf972)
  ) u_axi_mem_model (
    .clk        (clk),
    .rst_n      (rst_n),
    .ar_valid   (ar_valid),
    .ar_ready   (ar_ready),
    .ar         (ar),
    .r_valid    (r_valid),
    .r_ready    (r_ready),
    .r          (r),
    .ar_count   (ar_count),
    .last_id    (last_id),
    .last_len   (last_len),
    .last_addr  (last_addr),
    .last_size  (last_size),
    .last_burst (last_burst)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic next_rand_bit();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state[16];
  endfunction

  function automatic logic [31:0] phys(input logic [31:0] vaddr);
    return {3'b000, vaddr[28:0]};
  endfunction

  function automatic logic [31:0] line_base(input logic [31:0] vaddr);
    return phys(vaddr) & ~(line_bytes - 1);
  endfunction

  // only kseg0 and kseg1 word addresses reach memory
  function automatic fetch_resp_t expected_resp(input logic [31:0] vaddr);
    fetch_resp_t e;
    e.err   = ((vaddr[31:29] != seg_kseg0) && (vaddr[31:29] != seg_kseg1)) ||
              (vaddr[1:0] != 2'b00);
    e.rdata = e.err ? 32'h0 : (phys(vaddr) ^ mem_pattern);
    return e;
  endfunction

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic apply_reset();
    rst_n      = 1'b0;
    req_valid  = 1'b0;
    resp_ready = 1'b0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
  endtask

  // starts and ends on a falling edge
  task automatic send_req(input string name, input logic [31:0] vaddr);
    int cycles;
    cycles    = 0;
    req_valid = 1'b1;
    req.vaddr = vaddr;
    while (!req_ready) begin
      @(negedge clk);
      cycles = cycles + 1;
      if (cycles > timeout_cycles) begin
        report_fail($sformatf("%s: the request was never accepted", name));
      end
    end
    @(negedge clk);
    req_valid = 1'b0;
  endtask

  task automatic take_resp(input string name, input fetch_resp_t exp, input bit stall);
    fetch_resp_t held;
    bit          seen;
    bit          done;
    int          cycles;
    seen   = 1'b0;
    done   = 1'b0;
    cycles = 0;
    while (!done) begin
      @(negedge clk);
      resp_ready = stall ? next_rand_bit() : 1'b1;
      if (seen) begin
        assert (resp_valid && resp == held) else begin
          report_fail($sformatf("ERR %s: expected held %h valid 1, actual %h valid %b",
                                name, held, resp, resp_valid));
        end
      end
      if (resp_valid) begin
        held = resp;
        seen = 1'b1;
        if (resp_ready) begin
          assert (resp == exp) else begin
            report_fail($sformatf("ERR %s: expected rdata %h err %b, actual rdata %h err %b",
                                  name, exp.rdata, exp.err, resp.rdata, resp.err));
          end
          done = 1'b1;
        end
      end
      cycles = cycles + 1;
      if (!done && cycles > timeout_cycles) begin
        report_fail($sformatf("%s: no response arrived in time", name));
      end
    end
  endtask

  task automatic read_one(input string name, input logic [31:0] vaddr);
    fork
      send_req(name, vaddr);
      take_resp(name, expected_resp(vaddr), 1'b0);
    join
  endtask

  task automatic check_ar_count(input string name, input int exp);
    assert (ar_count == exp) else begin
      report_fail($sformatf("ERR %s: expected AR count %0d, actual %0d", name, exp, ar_count));
    end
  endtask

  // word beats in an INCR burst under the configured id
  task automatic check_last_ar(input string name, input logic [31:0] addr,
                               input logic [7:0] len);
    assert (last_addr == addr) else begin
      report_fail($sformatf("ERR %s: expected araddr %h, actual %h", name, addr, last_addr));
    end
    assert (last_len == len) else begin
      report_fail($sformatf("ERR %s: expected arlen %0d, actual %0d", name, len, last_len));
    end
    assert (last_size == 3'b010) else begin
      report_fail($sformatf("ERR %s: expected arsize %b, actual %b",
                            name, 3'b010, last_size));
    end
    assert (last_burst == 2'b01) else begin
      report_fail($sformatf("ERR %s: expected arburst %b, actual %b",
                            name, 2'b01, last_burst));
    end
    assert (last_id == 4'(axi_id)) else begin
      report_fail($sformatf("ERR %s: expected arid %0d, actual %0d",
                            name, axi_id, last_id));
    end
  endtask

  task automatic test_uncached();
    logic [31:0] va;
    int          c0;
    va = 32'ha000_1230;
    c0 = ar_count;
    read_one("uncached", va);
    check_ar_count("uncached", c0 + 1);
    check_last_ar("uncached", phys(va), 8'd0);
    read_one("uncached repeat", va);
    check_ar_count("uncached repeat", c0 + 2);
    check_last_ar("uncached repeat", phys(va), 8'd0);
  endtask

  task automatic test_cached_line();
    logic [31:0] va;
    int          c0;
    va = 32'h8000_2048;
    c0 = ar_count;
    read_one("cached miss", va);
    check_ar_count("cached miss", c0 + 1);
    check_last_ar("cached miss", line_base(va), 8'(line_words - 1));
    for (int i = 0; i < line_words; i++) begin
      read_one("cached hit", 32'h8000_2040 + 4 * i);
      check_ar_count("cached hit", c0 + 1);
    end
  endtask

  // both lines land in set 0 with different tags
  task automatic test_conflict();
    logic [31:0] va_a;
    logic [31:0] va_b;
    int          c0;
    va_a = 32'h8000_3104;
    va_b = 32'h8000_5108;
    c0   = ar_count;
    for (int i = 0; i < 3; i++) begin
      read_one("conflict a", va_a);
      check_ar_count("conflict a", c0 + 2 * i + 1);
      check_last_ar("conflict a", line_base(va_a), 8'(line_words - 1));
      read_one("conflict b", va_b);
      check_ar_count("conflict b", c0 + 2 * i + 2);
      check_last_ar("conflict b", line_base(va_b), 8'(line_words - 1));
    end
  endtask

  task automatic test_addr_error();
    logic [31:0] bad [4];
    int          c0;
    bad[0] = 32'h0000_1000;
    bad[1] = 32'hc000_1000;
    bad[2] = 32'h8000_1002;
    bad[3] = 32'ha000_0001;
    c0     = ar_count;
    for (int i = 0; i < 4; i++) begin
      read_one("addr error", bad[i]);
      check_ar_count("addr error", c0);
    end
  endtask

  // hits, misses, uncached and errors back to back under response stalls
  task automatic test_stream();
    logic [31:0] mix [11];
    mix[0]  = 32'h8000_2044;
    mix[1]  = 32'ha000_0100;
    mix[2]  = 32'h8000_4000;
    mix[3]  = 32'h8000_4004;
    mix[4]  = 32'h0000_0010;
    mix[5]  = 32'h8000_5104;
    mix[6]  = 32'ha000_0104;
    mix[7]  = 32'h8000_4008;
    mix[8]  = 32'hc000_0000;
    mix[9]  = 32'h8000_600c;
    mix[10] = 32'h8000_2002;
    fork
      begin
        for (int i = 0; i < 11; i++) begin
          send_req($sformatf("stream %0d", i), mix[i]);
        end
      end
      begin
        for (int j = 0; j < 11; j++) begin
          take_resp($sformatf("stream %0d", j), expected_resp(mix[j]), 1'b1);
        end
      end
    join
  endtask

  task automatic test_reset();
    logic [31:0] va;
    int          c0;
    va = 32'h8000_2044;
    apply_reset();
    assert (!resp_valid && !ar_valid && req_ready) else begin
      report_fail($sformatf("ERR reset: expected resp_valid 0 ar_valid 0 req_ready 1, %s",
                            $sformatf("actual %b %b %b", resp_valid, ar_valid, req_ready)));
    end
    c0 = ar_count;
    read_one("reset refill", va);
    check_ar_count("reset refill", c0 + 1);
    check_last_ar("reset refill", line_base(va), 8'(line_words - 1));
  endtask

  initial begin
    rng_state  = 32'hf972;
    rst_n      = 1'b0;
    req_valid  = 1'b0;
    req        = '0;
    resp_ready = 1'b0;
    apply_reset();
    test_uncached();
    test_cached_line();
    test_conflict();
    test_addr_error();
    test_stream();
    test_reset();
    $display("NO ERRORS");
    $finish;
  end

endmodule

//--- sim.f
design/mips_mem_pkg.sv
design/axi_pkg.sv
design/addr_xlate.sv
design/fetch_cache.sv
design/axi_read_bridge.sv
design/fetch_mem_top.sv
dv/axi_mem_model.sv
dv/tb_fetch_mem.sv
